// ==== compile.f ====
+incdir+src
src/exu_pkg.sv
src/exu_regfile.sv
src/exu_alu.sv
src/exu_bru.sv
src/exu_lsu.sv
src/exu_ecl.sv
src/exu_top.sv
verif/tb_clkgen.sv
verif/tb_exu.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_exu
FLIST     = compile.f
SIM_BIN   = obj_dir/V$(TOP)

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)
	@out=$$(./$(SIM_BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -q "^TEST OK$$"

clean:
	rm -rf obj_dir

// ==== verif/exu_vectors.txt ====
# test unit op rs1 rs2 rd wen use_imm imm pc flag addr data, all hex
# unit 0 alu 1 branch 2 memory; flag is taken or store strobe; data is wb value or target
2 0 a 00 00 01 1 1 12345000 00000100 0 0 12345000
2 0 0 00 00 02 1 1 fffffff0 00000104 0 0 fffffff0
2 0 0 01 02 03 1 0 00000000 00000108 0 0 12344ff0
2 0 1 01 02 04 1 0 00000000 0000010c 0 0 12345010
2 0 2 01 02 05 1 0 00000000 00000110 0 0 12345000
2 0 3 01 00 06 1 1 000000ff 00000114 0 0 123450ff
2 0 4 01 02 07 1 0 00000000 00000118 0 0 edcbaff0
2 0 5 02 01 08 1 0 00000000 0000011c 0 0 00000001
2 0 6 02 01 09 1 0 00000000 00000120 0 0 00000000
2 0 7 01 00 0a 1 1 00000004 00000124 0 0 23450000
2 0 8 02 00 0b 1 1 00000008 00000128 0 0 00ffffff
2 0 9 02 00 0c 1 1 00000004 0000012c 0 0 ffffffff
3 0 0 00 00 0d 1 1 00000005 00000130 0 0 00000005
3 0 0 0d 0d 0d 1 0 00000000 00000134 0 0 0000000a
3 0 7 0d 00 0e 1 1 00000001 00000138 0 0 00000014
3 0 0 0e 0d 0f 1 0 00000000 0000013c 0 0 0000001e
3 0 0 0f 00 00 1 1 00000007 00000140 0 0 00000000
3 0 0 00 00 10 1 1 00000003 00000144 0 0 00000003
3 0 4 00 0f 11 1 0 00000000 00000148 0 0 0000001e
4 1 0 01 01 00 0 0 00000040 00000200 1 0 00000240
4 1 1 01 01 00 0 0 00000040 00000204 0 0 00000000
4 1 2 02 01 00 0 0 fffffff8 00000208 1 0 00000200
4 1 3 02 01 00 0 0 00000010 0000020c 0 0 00000000
4 1 4 02 01 00 0 0 00000010 00000210 0 0 00000000
4 1 5 02 01 00 0 0 00000010 00000214 1 0 00000224
4 1 6 00 00 12 1 0 00000100 00000218 1 0 00000318
4 0 0 12 00 13 1 1 00000001 0000021c 0 0 0000021d
5 0 0 00 00 14 1 1 00000040 00000220 0 0 00000040
5 0 0 00 00 15 1 1 11223344 00000224 0 0 11223344
5 0 0 00 00 16 1 1 000000a5 00000228 0 0 000000a5
5 2 3 14 15 00 0 0 00000008 0000022c f 48 11223344
5 2 4 14 16 00 0 0 00000009 00000230 2 49 0000a500
5 2 0 14 00 17 1 0 00000008 00000234 0 48 1122a544
5 2 1 14 00 18 1 0 00000009 00000238 0 49 ffffffa5
5 2 2 14 00 19 1 0 00000009 0000023c 0 49 000000a5
5 2 1 14 00 1a 1 0 0000000b 00000240 0 4b 00000011
5 0 0 18 19 1b 1 0 00000000 00000244 0 0 0000004a

// ==== verif/tb_exu.sv ====
module tb_exu;

   timeunit 1ns;
   timeprecision 100ps;

   localparam int WAIT_MAX = 40;

   typedef struct packed {
      int                cyc;
      exu_pkg::reg_idx_t rd;
      exu_pkg::word_t    data;
      exu_pkg::word_t    pc;
   } wb_exp_t;

   typedef struct packed {
      int             cyc;
      logic           taken;
      exu_pkg::word_t target;
   } br_exp_t;

   typedef struct packed {
      exu_pkg::word_t addr;
      logic           wr;
      exu_pkg::strb_t strb;
      exu_pkg::word_t data;
   } mem_exp_t;

   logic                clk;
   logic                rst_n;
   logic                issue_valid;
   exu_pkg::issue_pkt_t issue;
   logic                stall;
   exu_pkg::mem_req_t   mem_req;
   logic                data_addr_ok;
   logic                data_data_ok;
   exu_pkg::word_t      data_rdata;
   exu_pkg::br_res_t    br;
   exu_pkg::wb_pkt_t    wb;

   wb_exp_t        wbq[$];
   br_exp_t        brq[$];
   mem_exp_t       memq[$];
   exu_pkg::word_t mem [0:63];
   int             cyc = 0;
   int             checks = 0;
   int             errors = 0;
   int             tests = 0;
   int             ph = 0;
   int             load_wb_cyc = -1;
   bit             timed_out = 0;
   bit             mon_on = 0;

   tb_clkgen clkgen (.clk(clk), .rst_n(rst_n));

   exu_top dut0 (
      .clk          (clk),
      .rst_n        (rst_n),
      .issue_valid  (issue_valid),
      .issue        (issue),
      .stall        (stall),
      .mem_req      (mem_req),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata),
      .br           (br),
      .wb           (wb)
   );

   always @(posedge clk) cyc <= cyc + 1;

   task automatic check_word(input string name, input exu_pkg::word_t got,
                             input exu_pkg::word_t exp);
      checks++;
      assert (got === exp) else begin
         $display("ERR %s got %h expected %h (cycle %0d)", name, got, exp, cyc);
         errors++;
      end
   endtask

   task automatic check_true(input logic cond, input string msg);
      checks++;
      assert (cond === 1'b1) else begin
         $display("%s (cycle %0d)", msg, cyc);
         errors++;
      end
   endtask

   // memory model with 0 to 3 wait cycles on each phase
   initial begin
      int wa;
      int wd;
      mem_exp_t cur;
      data_addr_ok = 1'b0;
      data_data_ok = 1'b0;
      data_rdata   = '0;
      wa  = 0;
      wd  = 0;
      cur = '0;
      for (int i = 0; i < 64; i++) begin
         mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000;
      end
      forever begin
         @(posedge clk);
         #1;
         data_addr_ok = 1'b0;
         data_data_ok = 1'b0;
         if (rst_n) begin
            if (ph != 0) begin
               check_true(stall, "stall dropped while a memory access was outstanding");
            end else if (mem_req.req) begin
               if (memq.size() == 0) begin
                  check_true(1'b0, "memory request with no memory instruction issued");
               end else begin
                  cur = memq.pop_front();
                  check_word("mem_req.addr", mem_req.addr, cur.addr);
                  check_word("mem_req.wr", 32'(mem_req.wr), 32'(cur.wr));
                  if (cur.wr) begin
                     check_word("mem_req.wstrb", 32'(mem_req.wstrb), 32'(cur.strb));
                     check_word("mem_req.wdata", mem_req.wdata, cur.data);
                  end
               end
               ph = 1;
               wa = int'($urandom % 4);
               wd = int'($urandom % 4);
            end
            if (ph == 1) begin
               if (wa > 0) begin
                  wa--;
               end else begin
                  data_addr_ok = 1'b1;
                  for (int b = 0; b < 4; b++) begin
                     if (mem_req.wr && mem_req.wstrb[b]) begin
                        mem[mem_req.addr[7:2]][8*b +: 8] = mem_req.wdata[8*b +: 8];
                     end
                  end
                  ph = 2;
               end
            end
            if (ph == 2) begin
               if (wd > 0) begin
                  wd--;
               end else begin
                  data_data_ok = 1'b1;
                  data_rdata   = mem[cur.addr[7:2]];
                  if (!cur.wr) begin
                     load_wb_cyc = cyc + 1;
                  end
                  ph = 0;
               end
            end
         end
      end
   end

   // watches br and wb each cycle at the falling edge
   always @(negedge clk) begin
      wb_exp_t e;
      int exp_cyc;
      if (mon_on) begin
         if (brq.size() > 0 && brq[0].cyc == cyc) begin
            check_word("br.taken", 32'(br.taken), 32'(brq[0].taken));
            if (brq[0].taken) begin
               check_word("br.target", br.target, brq[0].target);
            end
            void'(brq.pop_front());
         end else begin
            check_word("br.taken", 32'(br.taken), 32'h0);
         end
         if (wbq.size() > 0) begin
            exp_cyc = (wbq[0].cyc >= 0) ? wbq[0].cyc : load_wb_cyc;
         end else begin
            exp_cyc = -1;
         end
         if (wb.wen) begin
            if (wbq.size() == 0) begin
               check_true(1'b0, "write-back seen with no write expected");
            end else begin
               e = wbq.pop_front();
               check_true(cyc == exp_cyc, "write-back came in the wrong cycle");
               check_word("wb.rd", 32'(wb.rd), 32'(e.rd));
               check_word("wb.data", wb.data, e.data);
               check_word("wb.pc", wb.pc, e.pc);
               if (e.cyc < 0) begin
                  check_true(!stall, "stall still high at the load write-back");
                  load_wb_cyc = -1;
               end
            end
         end else if (exp_cyc >= 0 && cyc > exp_cyc) begin
            check_true(1'b0, "expected write-back never appeared");
            void'(wbq.pop_front());
         end
      end
   end

   task automatic issue_one(input exu_pkg::issue_pkt_t pkt, input exu_pkg::word_t flag,
                            input exu_pkg::word_t addr, input exu_pkg::word_t data);
      int n;
      int acc;
      logic is_store;
      n = 0;
      is_store = pkt.lsu_op == exu_pkg::lsu_st_w || pkt.lsu_op == exu_pkg::lsu_st_b;
      issue       = pkt;
      issue_valid = 1'b1;
      @(negedge clk);
      while (stall && !timed_out) begin
         n++;
         if (n > WAIT_MAX) begin
            $display("timeout waiting for stall to drop, pc %h", pkt.pc);
            timed_out = 1'b1;
         end else begin
            @(negedge clk);
         end
      end
      if (!timed_out) begin
         acc = cyc + 1;
         case (pkt.unit)
            exu_pkg::unit_bru: begin
               brq.push_back('{acc, flag[0], data});
               if (pkt.rf_wen && pkt.rd != '0) begin
                  wbq.push_back('{acc + 1, pkt.rd, pkt.pc + 32'd4, pkt.pc});
               end
            end
            exu_pkg::unit_lsu: begin
               memq.push_back('{addr, is_store, flag[3:0], data});
               if (!is_store && pkt.rf_wen && pkt.rd != '0) begin
                  wbq.push_back('{-1, pkt.rd, data, pkt.pc});
               end
            end
            default: begin
               if (pkt.rf_wen && pkt.rd != '0) begin
                  wbq.push_back('{acc + 1, pkt.rd, data, pkt.pc});
               end
            end
         endcase
      end
      @(posedge clk);
      #1;
      issue_valid = 1'b0;
   endtask

   task automatic finish_test(input int num, input int err_start);
      int n;
      n = 0;
      while ((wbq.size() != 0 || brq.size() != 0 || memq.size() != 0 || ph != 0)
             && !timed_out) begin
         n++;
         if (n > WAIT_MAX) begin
            $display("timeout waiting for test %0d to drain", num);
            timed_out = 1'b1;
         end else begin
            @(negedge clk);
         end
      end
      tests++;
      $display("test %0d finished with %0d errors", num, errors - err_start);
      @(posedge clk);
      #1;
   endtask

   task automatic run_vectors();
      int fd;
      int cur;
      int err_start;
      string line;
      logic [31:0] t, u, op, r1, r2, rd, wen, ui, imm, pc, flg, ad, dat;
      exu_pkg::issue_pkt_t pkt;
      cur = 0;
      err_start = errors;
      fd = $fopen("verif/exu_vectors.txt", "r");
      if (fd == 0) begin
         $display("could not open the vector file");
         errors++;
      end else begin
         while (!$feof(fd) && !timed_out) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#") begin
               if ($sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                           t, u, op, r1, r2, rd, wen, ui, imm, pc, flg, ad, dat) == 13) begin
                  if (int'(t) != cur && cur != 0) begin
                     finish_test(cur, err_start);
                     err_start = errors;
                  end
                  cur = int'(t);
                  pkt         = '0;
                  pkt.unit    = exu_pkg::unit_e'(u[1:0]);
                  pkt.alu_op  = exu_pkg::alu_op_e'(op[3:0]);
                  pkt.bru_op  = exu_pkg::bru_op_e'(op[2:0]);
                  pkt.lsu_op  = exu_pkg::lsu_op_e'(op[2:0]);
                  pkt.rs1     = r1[4:0];
                  pkt.rs2     = r2[4:0];
                  pkt.rd      = rd[4:0];
                  pkt.rf_wen  = wen[0];
                  pkt.use_imm = ui[0];
                  pkt.imm     = imm;
                  pkt.pc      = pc;
                  issue_one(pkt, flg, ad, dat);
               end
            end
         end
         $fclose(fd);
         if (cur != 0 && !timed_out) begin
            finish_test(cur, err_start);
         end
      end
   endtask

   initial begin
      int n;
      int err_start;
      n = 0;
      err_start = 0;
      issue_valid = 1'b0;
      issue       = '0;
      void'($urandom(32'h0220_51c5));
      @(posedge clk);
      // reset and the first cycle after it
      while (!rst_n && !timed_out) begin
         @(negedge clk);
         n++;
         if (n > WAIT_MAX) begin
            $display("timeout waiting for reset to be released");
            timed_out = 1'b1;
         end
         check_word("stall", 32'(stall), 32'h0);
         check_word("mem_req.req", 32'(mem_req.req), 32'h0);
         check_word("br.taken", 32'(br.taken), 32'h0);
         check_word("wb.wen", 32'(wb.wen), 32'h0);
      end
      tests++;
      $display("test 1 finished with %0d errors", errors - err_start);
      @(posedge clk);
      #1;
      mon_on = 1'b1;
      if (!timed_out) begin
         run_vectors();
      end
      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0 && !timed_out) begin
         $display("TEST OK");
      end else begin
         $display("TEST FAILED");
      end
      $finish;
   end

endmodule

// ==== verif/tb_clkgen.sv ====
module tb_clkgen (
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // released just after the eighth edge
   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      #1 rst_n = 1'b1;
   end

endmodule

// ==== src/exu_top.sv ====
module exu_top (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                issue_valid,
   input  exu_pkg::issue_pkt_t issue,
   output logic                stall,
   output exu_pkg::mem_req_t   mem_req,
   input  logic                data_addr_ok,
   input  logic                data_data_ok,
   input  exu_pkg::word_t      data_rdata,
   output exu_pkg::br_res_t    br,
   output exu_pkg::wb_pkt_t    wb
);

   exu_pkg::reg_idx_t rf_rs1;
   exu_pkg::reg_idx_t rf_rs2;
   exu_pkg::word_t    rf_rs1_data;
   exu_pkg::word_t    rf_rs2_data;

   exu_pkg::word_t    alu_a;
   exu_pkg::word_t    alu_b;
   exu_pkg::alu_op_e  alu_op;
   exu_pkg::word_t    alu_res;

   logic              bru_valid;
   exu_pkg::bru_op_e  bru_op;
   exu_pkg::word_t    bru_a;
   exu_pkg::word_t    bru_b;
   exu_pkg::word_t    bru_pc;
   exu_pkg::word_t    bru_offset;
   exu_pkg::word_t    bru_link;

   exu_pkg::lsu_cmd_t lsu_cmd;
   logic              lsu_done;
   exu_pkg::word_t    lsu_rdata;

   exu_ecl ecl (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue       (issue),
      .stall       (stall),
      .rs1         (rf_rs1),
      .rs2         (rf_rs2),
      .rs1_data    (rf_rs1_data),
      .rs2_data    (rf_rs2_data),
      .alu_a       (alu_a),
      .alu_b       (alu_b),
      .alu_op      (alu_op),
      .alu_res     (alu_res),
      .bru_valid   (bru_valid),
      .bru_op      (bru_op),
      .bru_a       (bru_a),
      .bru_b       (bru_b),
      .bru_pc      (bru_pc),
      .bru_offset  (bru_offset),
      .bru_link    (bru_link),
      .lsu_cmd     (lsu_cmd),
      .lsu_done    (lsu_done),
      .lsu_rdata   (lsu_rdata),
      .wb          (wb)
   );

   // written from the write-back stage
   exu_regfile regfile (
      .clk      (clk),
      .rs1      (rf_rs1),
      .rs2      (rf_rs2),
      .rs1_data (rf_rs1_data),
      .rs2_data (rf_rs2_data),
      .wen      (wb.wen),
      .rd       (wb.rd),
      .wdata    (wb.data)
   );

   exu_alu alu (
      .a   (alu_a),
      .b   (alu_b),
      .op  (alu_op),
      .res (alu_res)
   );

   exu_bru bru (
      .op     (bru_op),
      .a      (bru_a),
      .b      (bru_b),
      .pc     (bru_pc),
      .offset (bru_offset),
      .valid  (bru_valid),
      .res    (br),
      .link   (bru_link)
   );

   exu_lsu lsu (
      .clk          (clk),
      .rst_n        (rst_n),
      .cmd          (lsu_cmd),
      .mem_req      (mem_req),
      .data_addr_ok (data_addr_ok),
      .data_data_ok (data_data_ok),
      .data_rdata   (data_rdata),
      .done         (lsu_done),
      .rdata        (lsu_rdata)
   );

endmodule

// ==== src/exu_ecl.sv ====
module exu_ecl (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                issue_valid,
   input  exu_pkg::issue_pkt_t issue,
   output logic                stall,
   output exu_pkg::reg_idx_t   rs1,
   output exu_pkg::reg_idx_t   rs2,
   input  exu_pkg::word_t      rs1_data,
   input  exu_pkg::word_t      rs2_data,
   output exu_pkg::word_t      alu_a,
   output exu_pkg::word_t      alu_b,
   output exu_pkg::alu_op_e    alu_op,
   input  exu_pkg::word_t      alu_res,
   output logic                bru_valid,
   output exu_pkg::bru_op_e    bru_op,
   output exu_pkg::word_t      bru_a,
   output exu_pkg::word_t      bru_b,
   output exu_pkg::word_t      bru_pc,
   output exu_pkg::word_t      bru_offset,
   input  exu_pkg::word_t      bru_link,
   output exu_pkg::lsu_cmd_t   lsu_cmd,
   input  logic                lsu_done,
   input  exu_pkg::word_t      lsu_rdata,
   output exu_pkg::wb_pkt_t    wb
);

   exu_pkg::issue_pkt_t dec_pkt;
   exu_pkg::word_t      dec_a;
   exu_pkg::word_t      dec_b;
   logic                ex_valid;
   exu_pkg::issue_pkt_t ex_pkt;
   exu_pkg::word_t      ex_a;
   exu_pkg::word_t      ex_b;
   exu_pkg::word_t      ex_res;
   logic                ex_wen;
   logic                ex_mem;
   logic                ex_load;
   logic                wb_wen_nxt;

   // youngest producer wins over older ones and the register file
   function automatic exu_pkg::word_t fwd_sel(input exu_pkg::reg_idx_t idx,
                                              input exu_pkg::word_t rf_val);
      if (ex_wen && ex_pkt.rd == idx) begin
         return ex_res;
      end else if (wb.wen && wb.rd == idx) begin
         return wb.data;
      end
      return rf_val;
   endfunction

   assign rs1 = issue.rs1;
   assign rs2 = issue.rs2;

   // writes to r0 are dropped here so they are never forwarded
   always_comb begin
      dec_pkt        = issue;
      dec_pkt.rf_wen = issue.rf_wen && issue.rd != '0;
   end

   assign dec_a = fwd_sel(issue.rs1, rs1_data);
   assign dec_b = fwd_sel(issue.rs2, rs2_data);

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ex_valid <= 1'b0;
      end else if (!stall) begin
         ex_valid <= issue_valid;
      end else if (lsu_done) begin
         ex_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (!stall) begin
         ex_pkt <= dec_pkt;
         ex_a   <= dec_a;
         ex_b   <= dec_b;
      end
   end

   assign ex_mem  = ex_pkt.unit == exu_pkg::unit_lsu;
   assign ex_load = ex_pkt.lsu_op == exu_pkg::lsu_ld_w || ex_pkt.lsu_op == exu_pkg::lsu_ld_b ||
                    ex_pkt.lsu_op == exu_pkg::lsu_ld_bu;
   assign ex_wen  = ex_valid && ex_pkt.rf_wen;

   // front end holds while a memory access sits in execute
   assign stall = ex_valid && ex_mem;

   assign alu_a  = ex_a;
   assign alu_b  = ex_pkt.use_imm ? ex_pkt.imm : ex_b;
   assign alu_op = ex_pkt.alu_op;

   assign bru_valid  = ex_valid && ex_pkt.unit == exu_pkg::unit_bru;
   assign bru_op     = ex_pkt.bru_op;
   assign bru_a      = ex_a;
   assign bru_b      = ex_b;
   assign bru_pc     = ex_pkt.pc;
   assign bru_offset = ex_pkt.imm;

   always_comb begin
      lsu_cmd.valid = ex_valid && ex_mem;
      lsu_cmd.op    = ex_pkt.lsu_op;
      lsu_cmd.addr  = ex_a + ex_pkt.imm;
      lsu_cmd.wdata = ex_b;
   end

   always_comb begin
      case (ex_pkt.unit)
         exu_pkg::unit_bru: ex_res = bru_link;
         exu_pkg::unit_lsu: ex_res = lsu_rdata;
         default:           ex_res = alu_res;
      endcase
   end

   // loads write back only once the data has arrived
   assign wb_wen_nxt = ex_wen && (!ex_mem || (lsu_done && ex_load));

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         wb.wen <= 1'b0;
      end else begin
         wb.wen <= wb_wen_nxt;
      end
   end

   always_ff @(posedge clk) begin
      wb.rd   <= ex_pkt.rd;
      wb.data <= ex_res;
      wb.pc   <= ex_pkt.pc;
   end

   // the LSU finishes only for the instruction that holds execute
   a_done_owner: assert property (@(posedge clk) disable iff (!rst_n)
      lsu_done |-> stall);

endmodule

// ==== src/exu_lsu.sv ====
`include "exu_cfg.svh"

module exu_lsu (
   input  logic              clk,
   input  logic              rst_n,
   input  exu_pkg::lsu_cmd_t cmd,
   output exu_pkg::mem_req_t mem_req,
   input  logic              data_addr_ok,
   input  logic              data_data_ok,
   input  exu_pkg::word_t    data_rdata,
   output logic              done,
   output exu_pkg::word_t    rdata
);

   typedef enum logic [1:0] {
      s_idle,
      s_addr,
      s_data
   } lsu_state_e;

   lsu_state_e state;
   lsu_state_e state_nxt;
   logic       req_on;
   logic       is_store;
   logic [1:0] byte_sel;
   logic [7:0] ld_byte;

   // request goes out in the same cycle the command shows up
   assign req_on = (state == s_idle && cmd.valid) || state == s_addr;

   always_comb begin
      state_nxt = state;
      case (state)
         s_idle, s_addr: begin
            if (req_on && data_addr_ok) begin
               state_nxt = data_data_ok ? s_idle : s_data;
            end else if (req_on) begin
               state_nxt = s_addr;
            end
         end
         s_data: begin
            if (data_data_ok) begin
               state_nxt = s_idle;
            end
         end
         default: begin
            state_nxt = s_idle;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state <= s_idle;
      end else begin
         state <= state_nxt;
      end
   end

   // addr_ok and data_ok may land on the same edge
   assign done = (req_on && data_addr_ok && data_data_ok) || (state == s_data && data_data_ok);

   assign is_store = cmd.op == exu_pkg::lsu_st_w || cmd.op == exu_pkg::lsu_st_b;
   assign byte_sel = cmd.addr[1:0];

   always_comb begin
      mem_req.req  = req_on;
      mem_req.addr = cmd.addr;
      mem_req.wr   = is_store;
      case (cmd.op)
         exu_pkg::lsu_st_w: begin
            mem_req.wstrb = {`EXU_STRB_W{1'b1}};
            mem_req.wdata = cmd.wdata;
         end
         // byte on its own lane, others zero
         exu_pkg::lsu_st_b: begin
            mem_req.wstrb = exu_pkg::strb_t'(1) << byte_sel;
            mem_req.wdata = exu_pkg::word_t'(cmd.wdata[7:0]) << {byte_sel, 3'b000};
         end
         default: begin
            mem_req.wstrb = '0;
            mem_req.wdata = cmd.wdata;
         end
      endcase
   end

   assign ld_byte = 8'(data_rdata >> {byte_sel, 3'b000});

   always_comb begin
      case (cmd.op)
         exu_pkg::lsu_ld_b:  rdata = {{(`EXU_XLEN-8){ld_byte[7]}}, ld_byte};
         exu_pkg::lsu_ld_bu: rdata = {{(`EXU_XLEN-8){1'b0}}, ld_byte};
         default:            rdata = data_rdata;
      endcase
   end

   // request held steady until the memory takes the address
   a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      mem_req.req && !data_addr_ok |=> mem_req.req && $stable(mem_req));

endmodule

// ==== src/exu_bru.sv ====
`include "exu_cfg.svh"

module exu_bru (
   input  exu_pkg::bru_op_e op,
   input  exu_pkg::word_t   a,
   input  exu_pkg::word_t   b,
   input  exu_pkg::word_t   pc,
   input  exu_pkg::word_t   offset,
   input  logic            valid,
   output exu_pkg::br_res_t res,
   output exu_pkg::word_t   link
);

   logic eq;
   logic lt_s;
   logic lt_u;
   logic cond;

   assign eq   = a == b;
   assign lt_s = $signed(a) < $signed(b);
   assign lt_u = a < b;

   always_comb begin
      case (op)
         exu_pkg::bru_beq:  cond = eq;
         exu_pkg::bru_bne:  cond = !eq;
         exu_pkg::bru_blt:  cond = lt_s;
         exu_pkg::bru_bge:  cond = !lt_s;
         exu_pkg::bru_bltu: cond = lt_u;
         exu_pkg::bru_bgeu: cond = !lt_u;
         // unconditional
         exu_pkg::bru_jal:  cond = 1'b1;
         default:           cond = 1'b0;
      endcase
   end

   always_comb begin
      res.taken  = valid && cond;
      res.target = pc + offset;
   end

   // return address for jal
   assign link = pc + `EXU_XLEN'(`EXU_INST_BYTES);

endmodule

// ==== src/exu_alu.sv ====
`include "exu_cfg.svh"

module exu_alu (
   input  exu_pkg::word_t   a,
   input  exu_pkg::word_t   b,
   input  exu_pkg::alu_op_e op,
   output exu_pkg::word_t   res
);

   logic [4:0] shamt;
   logic       lt_s;
   logic       lt_u;

   assign shamt = b[4:0];
   assign lt_s  = $signed(a) < $signed(b);
   assign lt_u  = a < b;

   always_comb begin
      case (op)
         exu_pkg::alu_add: begin
            res = a + b;
         end
         exu_pkg::alu_sub: begin
            res = a - b;
         end
         exu_pkg::alu_and: begin
            res = a & b;
         end
         exu_pkg::alu_or: begin
            res = a | b;
         end
         exu_pkg::alu_xor: begin
            res = a ^ b;
         end
         exu_pkg::alu_slt: begin
            res = {{(`EXU_XLEN-1){1'b0}}, lt_s};
         end
         exu_pkg::alu_sltu: begin
            res = {{(`EXU_XLEN-1){1'b0}}, lt_u};
         end
         exu_pkg::alu_sll: begin
            res = a << shamt;
         end
         exu_pkg::alu_srl: begin
            res = a >> shamt;
         end
         exu_pkg::alu_sra: begin
            res = $signed(a) >>> shamt;
         end
         // immediate comes in already shifted
         exu_pkg::alu_lui: begin
            res = b;
         end
         default: begin
            res = '0;
         end
      endcase
   end

endmodule

// ==== src/exu_regfile.sv ====
`include "exu_cfg.svh"

module exu_regfile (
   input  logic             clk,
   input  exu_pkg::reg_idx_t rs1,
   input  exu_pkg::reg_idx_t rs2,
   output exu_pkg::word_t    rs1_data,
   output exu_pkg::word_t    rs2_data,
   input  logic             wen,
   input  exu_pkg::reg_idx_t rd,
   input  exu_pkg::word_t    wdata
);

   // r0 has no storage
   exu_pkg::word_t regs [1:`EXU_NREGS-1];

   always_ff @(posedge clk) begin
      if (wen && rd != '0) begin
         regs[rd] <= wdata;
      end
   end

   // a write in this cycle shows up on the read side at once
   always_comb begin
      if (rs1 == '0) begin
         rs1_data = '0;
      end else if (wen && rd == rs1) begin
         rs1_data = wdata;
      end else begin
         rs1_data = regs[rs1];
      end
   end

   always_comb begin
      if (rs2 == '0) begin
         rs2_data = '0;
      end else if (wen && rd == rs2) begin
         rs2_data = wdata;
      end else begin
         rs2_data = regs[rs2];
      end
   end

endmodule

// ==== src/exu_pkg.sv ====
`include "exu_cfg.svh"

package exu_pkg;

   typedef logic [`EXU_XLEN-1:0]      word_t;
   typedef logic [`EXU_REG_IDX_W-1:0] reg_idx_t;
   typedef logic [`EXU_STRB_W-1:0]    strb_t;

   // which functional unit takes the instruction
   typedef enum logic [1:0] {
      unit_alu = 2'd0,
      unit_bru = 2'd1,
      unit_lsu = 2'd2
   } unit_e;

   // lui passes the immediate through on b
   typedef enum logic [3:0] {
      alu_add  = 4'd0,
      alu_sub  = 4'd1,
      alu_and  = 4'd2,
      alu_or   = 4'd3,
      alu_xor  = 4'd4,
      alu_slt  = 4'd5,
      alu_sltu = 4'd6,
      alu_sll  = 4'd7,
      alu_srl  = 4'd8,
      alu_sra  = 4'd9,
      alu_lui  = 4'd10
   } alu_op_e;

   typedef enum logic [2:0] {
      bru_beq  = 3'd0,
      bru_bne  = 3'd1,
      bru_blt  = 3'd2,
      bru_bge  = 3'd3,
      bru_bltu = 3'd4,
      bru_bgeu = 3'd5,
      bru_jal  = 3'd6
   } bru_op_e;

   typedef enum logic [2:0] {
      lsu_ld_w  = 3'd0,
      lsu_ld_b  = 3'd1,
      lsu_ld_bu = 3'd2,
      lsu_st_w  = 3'd3,
      lsu_st_b  = 3'd4
   } lsu_op_e;

   // one decoded instruction from the front end
   typedef struct packed {
      unit_e    unit;
      alu_op_e  alu_op;
      bru_op_e  bru_op;
      lsu_op_e  lsu_op;
      reg_idx_t rs1;
      reg_idx_t rs2;
      reg_idx_t rd;
      logic     rf_wen;
      logic     use_imm;
      word_t    imm;
      word_t    pc;
   } issue_pkt_t;

   typedef struct packed {
      logic     wen;
      reg_idx_t rd;
      word_t    data;
      word_t    pc;
   } wb_pkt_t;

   typedef struct packed {
      logic  req;
      word_t addr;
      logic  wr;
      strb_t wstrb;
      word_t wdata;
   } mem_req_t;

   typedef struct packed {
      logic    valid;
      lsu_op_e op;
      word_t   addr;
      word_t   wdata;
   } lsu_cmd_t;

   typedef struct packed {
      logic  taken;
      word_t target;
   } br_res_t;

endpackage

// ==== src/exu_cfg.svh ====
`ifndef EXU_CFG_SVH
`define EXU_CFG_SVH

// data and address width
`define EXU_XLEN 32

// general registers, r0 included
`define EXU_NREGS 32

// bits needed to name one register
`define EXU_REG_IDX_W 5

// byte lanes in one data word
`define EXU_STRB_W 4

// added to pc for the link address
`define EXU_INST_BYTES 4

`endif
